/* flist.f */
verilog/rvIsaPkg.sv
verilog/ctrlPkg.sv
verilog/instrClassifier.sv
verilog/aluOpDecoder.sv
verilog/mainFsm.sv
verilog/controller.sv
testbench/controllerProps.sv
testbench/controllerTb.sv

/* Makefile */
# Verilator build and run for the multicycle controller testbench

VERILATOR ?= verilator
TOP       := controllerTb
FLIST     := flist.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJDIR)
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* testbench/controllerTb.sv */
// Controller testbench with instruction model and bus responder
// Reference functions for ALU decoding and instruction timing
// Posedge checker and watchdog
`timescale 1ns/1ps
`default_nettype none

module controllerTb;
    import rvIsaPkg::*;
    import ctrlPkg::*;

    localparam int clkPeriod  = 8;
    localparam int numRandom  = 60;  // Random stream before the halt test
    localparam int numRestart = 4;   // Instructions after the second reset
    localparam int numInstr   = numRandom + 1 + numRestart;

    typedef enum {wantSetAddr, wantRead, wantRsp, wantNothing} phaseT;

    logic        clk;
    logic        reset;
    opcodeT      op;
    funct3T      funct3;
    logic        funct7b5;
    logic        zero;
    xlenT        pc;
    logic        cmdBusy;
    logic        rspStb;
    ctrlSignalsT ctrl;
    logic        cmdStb;
    busCmdT      cmdWord;
    logic        halted;

    integer      seed = 32'he0674aa4;
    instrClassT  curClass;   // Instruction held in the IR
    int          stallLen;   // Busy cycles right after its response
    int          stallLeft;
    int          errorCount;
    int          checkCount;
    phaseT       phase;      // Next event the checker accepts
    logic        counting;
    logic        firstCycle;
    int          sinceRsp;
    int          regWrites;
    int          memWrites;
    int          adrCycles;  // Data address taken from ALUOut
    int          expCycles;

    controller UUT (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .zero     (zero),
        .pc       (pc),
        .cmdBusy  (cmdBusy),
        .rspStb   (rspStb),
        .ctrl     (ctrl),
        .cmdStb   (cmdStb),
        .cmdWord  (cmdWord),
        .halted   (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // funct3 table of the ALU decoder
    function automatic aluCtrlT expectedAluControl(funct3T f3, logic f7b5, logic opBit5);
        case (f3)
            3'b000: return (f7b5 && opBit5) ? aluSub : aluAdd;  // sub only for R-type
            3'b010: return aluSlt;
            3'b110: return aluOr;
            3'b111: return aluAnd;
            default: return aluAdd;
        endcase
    endfunction

    // Response strobe to next set-address strobe
    function automatic int expectedCycles(instrClassT cls);
        case (cls)
            load: return 5;
            store, rType, iType, jal: return 4;
            beq: return 3;
            default: return 0;
        endcase
    endfunction

    // Immediate format of each instruction class
    function automatic immSrcT expectedImmSrc(instrClassT cls);
        case (cls)
            store: return immS;
            beq: return immB;
            jal: return immJ;
            default: return immI;  // Loads, I-type and unknown opcodes
        endcase
    endfunction

    function automatic opcodeT opcodeOf(instrClassT cls);
        case (cls)
            load: return opLoad;
            store: return opStore;
            rType: return opRType;
            iType: return opIType;
            jal: return opJal;
            beq: return opBranch;
            default: return 7'b1110011;  // SYSTEM opcode is not supported
        endcase
    endfunction

    function automatic instrClassT randomClass();
        logic [31:0] r;
        r = $unsigned($random(seed)) % 32'd6;  // Legal classes only
        return instrClassT'(r[2:0]);
    endfunction

    function automatic logic randomBusy();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0] == 2'b00;  // Busy about a quarter of the time
    endfunction

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        assert (got == exp)
        else
        begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, exp);
        end
    endtask

    task automatic reportFault(input string msg);
        errorCount++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic checkQuiet();
        compareField("ctrl.pcWrite", 32'(ctrl.pcWrite), 32'd0);
        compareField("ctrl.memWrite", 32'(ctrl.memWrite), 32'd0);
        compareField("ctrl.irWrite", 32'(ctrl.irWrite), 32'd0);
        compareField("ctrl.regWrite", 32'(ctrl.regWrite), 32'd0);
        compareField("cmdStb", 32'(cmdStb), 32'd0);
    endtask

    // First cycle after Decode
    task automatic checkExecute();
        case (curClass)
            rType: compareField("ctrl.aluControl", 32'(ctrl.aluControl),
                                32'(expectedAluControl(funct3, funct7b5, 1'b1)));
            iType: compareField("ctrl.aluControl", 32'(ctrl.aluControl),
                                32'(expectedAluControl(funct3, funct7b5, 1'b0)));
            beq: compareField("ctrl.pcWrite", 32'(ctrl.pcWrite), 32'(zero));
            illegal: compareField("halted", 32'(halted), 32'd1);
            default: ;
        endcase
    endtask

    task automatic startInstr();
        int base;
        compareField("ctrl.irWrite", 32'(ctrl.irWrite), 32'd1);
        compareField("ctrl.pcWrite", 32'(ctrl.pcWrite), 32'd1);
        compareField("ctrl.aluSrcA", 32'(ctrl.aluSrcA), 32'(srcAPc));
        compareField("ctrl.aluSrcB", 32'(ctrl.aluSrcB), 32'(srcBFour));
        compareField("ctrl.aluControl", 32'(ctrl.aluControl), 32'(aluAdd));
        base      = expectedCycles(curClass);
        expCycles = (stallLen + 1 > base) ? stallLen + 1 : base;  // Busy delays Fetch1
        counting  = 1'b1;
        sinceRsp  = 0;
        regWrites = 0;
        memWrites = 0;
        adrCycles = 0;
        phase     = (curClass == illegal) ? wantNothing : wantSetAddr;
    endtask

    task automatic checkStrobe();
        assert (phase == wantSetAddr || phase == wantRead)
        else
            reportFault("command strobe while no fetch command was due");
        if (phase == wantSetAddr)
        begin
            compareField("cmdWord.code", 32'(cmdWord.code), 32'(cmdSetAddr));
            compareField("cmdWord.payload", cmdWord.payload, pc);
            if (counting)
            begin
                compareField("cycles to next fetch", sinceRsp, expCycles);
                compareField("regWrite cycles", regWrites,
                             (curClass inside {load, rType, iType, jal}) ? 1 : 0);
                compareField("memWrite cycles", memWrites, (curClass == store) ? 1 : 0);
                compareField("adrSrc cycles", adrCycles,
                             (curClass inside {load, store}) ? 1 : 0);
                counting = 1'b0;
            end
            phase = wantRead;
        end
        else if (phase == wantRead)
        begin
            compareField("cmdWord.code", 32'(cmdWord.code), 32'(cmdRead));
            compareField("cmdWord.payload", cmdWord.payload, 32'd0);
            phase = wantRsp;
        end
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            checkQuiet();
            compareField("halted", 32'(halted), 32'd0);
            phase      = wantSetAddr;
            counting   = 1'b0;
            firstCycle = 1'b1;
        end
        else
        begin
            if (firstCycle)
                checkQuiet();  // Still in Reset
            firstCycle = 1'b0;
            assert (!(cmdStb && cmdBusy))
            else
                reportFault("command strobe raised while cmdBusy was high");
            if (counting)
            begin
                sinceRsp++;
                if (ctrl.regWrite)
                begin
                    regWrites++;
                    // Loads write back memory data
                    compareField("ctrl.resultSrc", 32'(ctrl.resultSrc),
                                 32'((curClass == load) ? resData : resAluOut));
                end
                if (ctrl.memWrite)
                    memWrites++;
                if (ctrl.adrSrc)
                    adrCycles++;
                if (sinceRsp == 1)
                begin
                    compareField("halted", 32'(halted), 32'd0);  // Decode
                    if (curClass != rType)  // R-type has no immediate
                        compareField("ctrl.immSrc", 32'(ctrl.immSrc),
                                     32'(expectedImmSrc(curClass)));
                end
                if (sinceRsp == 2)
                    checkExecute();
            end
            if (rspStb)
                startInstr();
            if (cmdStb)
                checkStrobe();
        end
    end

    // One cycle of the bus responder
    task automatic stepCycle(input logic busy);
        @(negedge clk);
        cmdBusy = busy;
        rspStb  = 1'b0;
        @(posedge clk);
    endtask

    task automatic fetchAddress();
        do
        begin
            stepCycle(stallLeft > 0);
            if (stallLeft > 0)
                stallLeft--;
        end
        while (!cmdStb);
    endtask

    task automatic runInstr(input instrClassT cls);
        logic [31:0] rnd;
        logic [31:0] pcRnd;
        int          delay;
        fetchAddress();
        do
            stepCycle(randomBusy());
        while (!cmdStb);  // Read strobe
        rnd   = $random(seed);
        pcRnd = $random(seed);
        delay = int'(rnd[11:10]);  // Response latency
        repeat (delay) stepCycle(randomBusy());
        @(negedge clk);
        op        = opcodeOf(cls);
        funct3    = rnd[2:0];
        funct7b5  = rnd[3];
        zero      = rnd[4];
        pc        = {pcRnd[31:2], 2'b00};
        curClass  = cls;
        stallLen  = rnd[5] ? 0 : int'(rnd[8:6]) + 1;  // Half the instructions stall
        stallLeft = stallLen;
        cmdBusy   = rnd[9];  // Ignored in FetchWait
        rspStb    = 1'b1;
        @(posedge clk);
    endtask

    task automatic applyReset();
        reset     = 1'b1;
        cmdBusy   = 1'b0;
        rspStb    = 1'b0;
        stallLeft = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
    endtask

    initial
    begin
        op       = opLoad;
        funct3   = 3'b000;
        funct7b5 = 1'b0;
        zero     = 1'b0;
        pc       = 32'h0000_1000;
        curClass = load;
        stallLen = 0;
        applyReset();
        repeat (numRandom) runInstr(randomClass());
        runInstr(illegal);
        repeat (12) stepCycle(randomBusy());  // Halted, nothing may strobe
        @(negedge clk);
        applyReset();
        repeat (numRestart) runInstr(randomClass());
        fetchAddress();  // Closes the timing check of the last instruction
        @(negedge clk);
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        #((numInstr * 40 + 200) * clkPeriod);
        $display("Watchdog expired: the controller stopped making progress");
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/controllerProps.sv */
// Concurrent assertions for the main FSM
// Command back-pressure, exclusive write enables, sticky halt
`timescale 1ns/1ps
`default_nettype none

module controllerProps (
    input wire clk,
    input wire reset,
    input wire cmdStb,
    input wire cmdBusy,
    input wire memWrite,
    input wire regWrite,
    input wire halted
);

    // No command goes out while the port is busy
    strobeNotBusy: assert property (@(posedge clk) disable iff (reset)
        !(cmdStb && cmdBusy))
    else
        $error("cmdStb asserted while cmdBusy is high");

    writesExclusive: assert property (@(posedge clk) disable iff (reset)
        !(memWrite && regWrite))  // Memory and register file never in one state
    else
        $error("memWrite and regWrite high in the same cycle");

    // Only reset leaves Halt
    haltSticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
    else
        $error("halted dropped without a reset");

endmodule

bind mainFsm controllerProps props (
    .clk      (clk),
    .reset    (reset),
    .cmdStb   (cmdStb),
    .cmdBusy  (cmdBusy),
    .memWrite (ctrl.memWrite),
    .regWrite (ctrl.regWrite),
    .halted   (halted)
);

`default_nettype wire

/* verilog/controller.sv */
// Control unit top level
// Classifier, ALU op decoder and main FSM
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  wire                        clk,
    input  wire                        reset,
    input  wire rvIsaPkg::opcodeT      op,
    input  wire rvIsaPkg::funct3T      funct3,
    input  wire                        funct7b5,
    input  wire                        zero,
    input  wire ctrlPkg::xlenT         pc,
    input  wire                        cmdBusy,
    input  wire                        rspStb,
    output wire ctrlPkg::ctrlSignalsT  ctrl,
    output wire                        cmdStb,
    output wire ctrlPkg::busCmdT       cmdWord,
    output wire                        halted
);
    import rvIsaPkg::*;
    import ctrlPkg::*;

    wire instrClassT instrClass;
    wire immSrcT     immSrc;
    wire aluModeT    aluMode;
    wire aluCtrlT    aluControl;  // Fed back into the control word

    instrClassifier classifier (
        .op         (op),
        .instrClass (instrClass),
        .immSrc     (immSrc)
    );

    aluOpDecoder aluDec (
        .aluMode    (aluMode),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .opBit5     (op[5]),  // Tells R-type from I-type
        .aluControl (aluControl)
    );

    mainFsm fsm (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .immSrc     (immSrc),
        .aluControl (aluControl),
        .zero       (zero),
        .pc         (pc),
        .cmdBusy    (cmdBusy),
        .rspStb     (rspStb),
        .aluMode    (aluMode),
        .ctrl       (ctrl),
        .cmdStb     (cmdStb),
        .cmdWord    (cmdWord),
        .halted     (halted)
    );

endmodule

`default_nettype wire

/* verilog/mainFsm.sv */
// Multicycle control FSM
// Fetch commands on the command port, next-state logic and Moore control word
`timescale 1ns/1ps
`default_nettype none

module mainFsm (
    input  wire                       clk,
    input  wire                       reset,
    input  wire rvIsaPkg::instrClassT instrClass,
    input  wire rvIsaPkg::immSrcT     immSrc,
    input  wire ctrlPkg::aluCtrlT     aluControl,
    input  wire                       zero,     // ALU result is zero
    input  wire ctrlPkg::xlenT        pc,
    input  wire                       cmdBusy,
    input  wire                       rspStb,   // Instruction word arrives
    output ctrlPkg::aluModeT          aluMode,
    output ctrlPkg::ctrlSignalsT      ctrl,
    output logic                      cmdStb,
    output ctrlPkg::busCmdT           cmdWord,
    output logic                      halted
);
    import rvIsaPkg::*;
    import ctrlPkg::*;

    fsmStateT    state;
    fsmStateT    nextState;
    ctrlSignalsT stateCtrl;  // Per-state part of the control word

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= Reset;
        end
        else
        begin
            state <= nextState;
        end
    end

    // Next state
    always_comb
    begin
        nextState = state;  // Hold unless told otherwise
        case (state)
            Reset:
                nextState = Fetch1;
            Fetch1:
            begin
                if (!cmdBusy)  // Set-address goes out this cycle
                    nextState = Fetch2;
            end
            Fetch2:
            begin
                if (!cmdBusy)  // Read goes out this cycle
                    nextState = FetchWait;
            end
            FetchWait:
            begin
                if (rspStb)
                    nextState = Decode;
            end
            Decode:
            begin
                case (instrClass)
                    load, store: nextState = MemAddr;
                    rType:       nextState = ExecuteR;
                    iType:       nextState = ExecuteI;
                    jal:         nextState = Jal;
                    beq:         nextState = Beq;
                    default:     nextState = Halt;
                endcase
            end
            MemAddr:
            begin
                if (instrClass == store)
                    nextState = MemWrite;
                else
                    nextState = MemRead;
            end
            MemRead:
                nextState = MemWB;
            ExecuteR, ExecuteI, Jal:
                nextState = AluWB;
            MemWB, MemWrite, AluWB, Beq:
                nextState = Fetch1;  // Instruction done
            Halt:
                nextState = Halt;    // Only reset leaves
            default:
                nextState = Halt;    // Unused encodings
        endcase
    end

    // ALU mode per state
    always_comb
    begin
        case (state)
            ExecuteR, ExecuteI:
                aluMode = modeFunct;
            Beq:
                aluMode = modeSub;
            default:
                aluMode = modeAdd;  // PC increment and address sums
        endcase
    end

    // Moore control outputs
    always_comb
    begin
        stateCtrl           = '0;  // No writes anywhere
        stateCtrl.resultSrc = resAluOut;
        stateCtrl.aluSrcA   = srcAPc;
        stateCtrl.aluSrcB   = srcBFour;
        case (state)
            FetchWait:
            begin
                stateCtrl.irWrite = rspStb;  // Capture the instruction word
                stateCtrl.pcWrite = rspStb;  // PC + 4 in the same cycle
            end
            Decode:
            begin
                stateCtrl.aluSrcA = srcAOldPc;  // Branch and jump target
                stateCtrl.aluSrcB = srcBImm;
            end
            MemAddr:
            begin
                stateCtrl.aluSrcA = srcARs1;  // Effective address
                stateCtrl.aluSrcB = srcBImm;
            end
            MemRead:
                stateCtrl.adrSrc = 1'b1;  // Address from ALUOut
            MemWB:
            begin
                stateCtrl.resultSrc = resData;
                stateCtrl.regWrite  = 1'b1;
            end
            MemWrite:
            begin
                stateCtrl.adrSrc   = 1'b1;
                stateCtrl.memWrite = 1'b1;
            end
            ExecuteR:
            begin
                stateCtrl.aluSrcA = srcARs1;
                stateCtrl.aluSrcB = srcBRs2;
            end
            ExecuteI:
            begin
                stateCtrl.aluSrcA = srcARs1;
                stateCtrl.aluSrcB = srcBImm;
            end
            AluWB:
                stateCtrl.regWrite = 1'b1;  // rd from ALUOut
            Jal:
            begin
                stateCtrl.aluSrcA = srcAOldPc;  // Link address
                stateCtrl.pcWrite = 1'b1;       // Target sits in ALUOut
            end
            Beq:
            begin
                stateCtrl.aluSrcA = srcARs1;
                stateCtrl.aluSrcB = srcBRs2;
                stateCtrl.pcWrite = zero;  // Taken only when equal
            end
            default:
                stateCtrl.pcWrite = 1'b0;
        endcase
    end

    // Fetch commands
    always_comb
    begin
        cmdStb  = 1'b0;
        cmdWord = '0;
        case (state)
            Fetch1:
            begin
                cmdStb          = !cmdBusy;  // Back-pressure holds the strobe
                cmdWord.code    = cmdSetAddr;
                cmdWord.payload = pc;
            end
            Fetch2:
            begin
                cmdStb       = !cmdBusy;
                cmdWord.code = cmdRead;  // Zero payload
            end
            default:
                cmdStb = 1'b0;
        endcase
    end

    assign halted = (state == Halt);

    // Merge in the decoded fields
    always_comb
    begin
        ctrl            = stateCtrl;
        ctrl.immSrc     = immSrc;      // Straight from the classifier
        ctrl.aluControl = aluControl;  // Follows aluMode
    end

endmodule

`default_nettype wire

/* verilog/aluOpDecoder.sv */
// ALU operation decoder
// Maps the FSM's ALU mode and the funct fields to an ALU control code
`timescale 1ns/1ps
`default_nettype none

module aluOpDecoder (
    input  wire ctrlPkg::aluModeT  aluMode,
    input  wire rvIsaPkg::funct3T  funct3,
    input  wire                    funct7b5,
    input  wire                    opBit5,  // Set for R-type
    output ctrlPkg::aluCtrlT       aluControl
);
    import rvIsaPkg::*;
    import ctrlPkg::*;

    always_comb
    begin
        case (aluMode)
            modeAdd:
                aluControl = aluAdd;
            modeSub:
                aluControl = aluSub;  // beq compares by subtraction
            modeFunct:
            begin
                case (funct3)
                    f3AddSub:
                    begin
                        // addi with a negative immediate must not become sub
                        if (funct7b5 && opBit5)
                            aluControl = aluSub;
                        else
                            aluControl = aluAdd;
                    end
                    f3Slt:
                        aluControl = aluSlt;
                    f3Or:
                        aluControl = aluOr;
                    f3And:
                        aluControl = aluAnd;
                    default:
                        aluControl = aluAdd;  // Unsupported funct3
                endcase
            end
            default:
                aluControl = aluAdd;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/instrClassifier.sv */
// Opcode classifier
// Gives the instruction class and immediate format of an opcode
`timescale 1ns/1ps
`default_nettype none

module instrClassifier (
    input  wire rvIsaPkg::opcodeT op,
    output rvIsaPkg::instrClassT  instrClass,
    output rvIsaPkg::immSrcT      immSrc
);
    import rvIsaPkg::*;

    // All raw opcode compares live here
    always_comb
    begin
        instrClass = illegal;  // Unknown opcodes trap
        immSrc     = immI;
        case (op)
            opLoad:
            begin
                instrClass = load;
                immSrc     = immI;  // Base plus offset
            end
            opStore:
            begin
                instrClass = store;
                immSrc     = immS;
            end
            opRType:
            begin
                instrClass = rType;
                immSrc     = immI;  // No immediate used
            end
            opIType:
            begin
                instrClass = iType;
                immSrc     = immI;
            end
            opJal:
            begin
                instrClass = jal;
                immSrc     = immJ;
            end
            opBranch:
            begin
                instrClass = beq;
                immSrc     = immB;  // Target computed in Decode
            end
            default:
            begin
                instrClass = illegal;
                immSrc     = immI;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ctrlPkg.sv */
// Datapath control word and its select codes
// ALU operations, fetch command format and controller states
`default_nettype none

package ctrlPkg;

    typedef logic [31:0] xlenT;      // Machine word
    typedef logic [2:0]  aluCtrlT;   // ALU operation
    typedef logic [1:0]  srcASel;    // ALU A mux
    typedef logic [1:0]  srcBSel;    // ALU B mux
    typedef logic [1:0]  resultSel;  // Result bus mux
    typedef logic [1:0]  busCodeT;   // Command code

    localparam aluCtrlT aluAdd = 3'd0;
    localparam aluCtrlT aluSub = 3'd1;
    localparam aluCtrlT aluAnd = 3'd2;
    localparam aluCtrlT aluOr  = 3'd3;
    localparam aluCtrlT aluSlt = 3'd5;

    // How the ALU op is chosen in a state
    typedef enum logic [1:0] {
        modeAdd,   // PC and address arithmetic
        modeSub,   // Branch compare
        modeFunct  // Taken from funct3 and funct7
    } aluModeT;

    localparam srcASel srcAPc    = 2'd0;
    localparam srcASel srcAOldPc = 2'd1;  // PC of the current instruction
    localparam srcASel srcARs1   = 2'd2;

    localparam srcBSel srcBRs2  = 2'd0;
    localparam srcBSel srcBImm  = 2'd1;  // Sign extended immediate
    localparam srcBSel srcBFour = 2'd2;  // Constant 4

    localparam resultSel resAluOut = 2'd0;  // ALUOut register
    localparam resultSel resData   = 2'd1;  // Memory data register

    localparam busCodeT cmdRead    = 2'd0;  // Read at the held address
    localparam busCodeT cmdSetAddr = 2'd2;  // Load address from payload

    typedef struct packed {
        busCodeT code;
        xlenT    payload;
    } busCmdT;

    // Everything the datapath receives from the controller
    typedef struct packed {
        logic             pcWrite;
        logic             adrSrc;     // 0 for PC and 1 for ALUOut
        logic             memWrite;
        logic             irWrite;
        logic             regWrite;
        resultSel         resultSrc;
        srcASel           aluSrcA;
        srcBSel           aluSrcB;
        rvIsaPkg::immSrcT immSrc;
        aluCtrlT          aluControl;
    } ctrlSignalsT;

    typedef enum logic [3:0] {
        Reset, Fetch1, Fetch2, FetchWait, Decode,
        MemAddr, MemRead, MemWB, MemWrite,
        ExecuteR, ExecuteI, AluWB, Jal, Beq,
        Halt = 4'hF  // Trap for unknown opcodes
    } fsmStateT;

endpackage

`default_nettype wire

/* verilog/rvIsaPkg.sv */
// RV32 opcode and funct3 encodings
// Immediate format codes and instruction classes
`default_nettype none

package rvIsaPkg;

    typedef logic [6:0] opcodeT;  // Instr[6:0]
    typedef logic [2:0] funct3T;  // Instr[14:12]
    typedef logic [1:0] immSrcT;  // Immediate extender select

    // Major opcodes handled by the core
    localparam opcodeT opLoad   = 7'b0000011;  // lw
    localparam opcodeT opStore  = 7'b0100011;  // sw
    localparam opcodeT opRType  = 7'b0110011;  // add sub and or slt
    localparam opcodeT opIType  = 7'b0010011;  // addi andi ori slti
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opBranch = 7'b1100011;  // Only beq supported

    // funct3 of the ALU group
    localparam funct3T f3AddSub = 3'b000;  // funct7 bit 5 picks sub
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // Immediate formats
    localparam immSrcT immI = 2'd0;  // Instr[31:20]
    localparam immSrcT immS = 2'd1;  // Split store offset
    localparam immSrcT immB = 2'd2;  // Branch offset in halfwords
    localparam immSrcT immJ = 2'd3;  // 20 bit jump offset

    // What the controller needs to know about an opcode
    typedef enum logic [2:0] {
        load,
        store,
        rType,
        iType,
        jal,
        beq,
        illegal  // Sends the FSM to Halt
    } instrClassT;

endpackage

`default_nettype wire
